// ==== Makefile ====
# Verilator build and run of the solo penalty shooter testbench

VERILATOR ?= verilator
TOP       ?= shoot_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= SIMULATION PASSED

SOURCES := $(wildcard design/*.sv design/*.svh bench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides pass or fail, the simulator exit code is not used
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "run failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/shoot_tb.sv ====
// shoot testbench: rounds, verdict timing and keeper overlay of the solo penalty shooter
`timescale 1ns/1ps
`include "shoot_defines.svh"

module shoot_tb;

    localparam int HOLD       = 20;
    localparam int MAX_CYCLES = 6000;   // about three times the test length
    localparam int POS_W      = `SHOOT_POS_W;
    localparam int CNT_W      = `SHOOT_CNT_W;

    logic                   clk;
    logic                   rst;
    shoot_pkg::game_phase_t game_phase;
    logic [POS_W-1:0]       xpos;
    logic [POS_W-1:0]       ypos;
    logic                   left_clicked;
    logic [CNT_W-1:0]       in_hcount;
    logic [CNT_W-1:0]       in_vcount;
    logic                   in_hsync, in_vsync, in_hblnk, in_vblnk;
    logic [11:0]            in_rgb;
    logic                   is_scored, round_done, end_sh;
    logic [CNT_W-1:0]       out_hcount;
    logic [CNT_W-1:0]       out_vcount;
    logic                   out_hsync, out_vsync, out_hblnk, out_vblnk;
    logic [11:0]            out_rgb;

    integer seed;
    int     errors, cycles, since, test_base, tests_run, tests_failed;
    string  test_name;
    logic   vga_chk, aim_click, chk_live, exp_goal, exp_valid;
    logic [CNT_W-1:0] exp_hcount;
    logic [CNT_W-1:0] exp_vcount;
    logic [3:0]       exp_sync;
    logic [11:0]      exp_rgb;
    shoot_pkg::keeper_tint_t exp_tint;

    shoot_top #(.hold_cycles(HOLD)) u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic in_keeper_box(input int x, input int y);
        return (x >= `SHOOT_GK_LEFT) && (x <= `SHOOT_GK_RIGHT) &&
               (y >= `SHOOT_GK_TOP) && (y <= `SHOOT_GK_BOTTOM);
    endfunction

    function automatic logic ref_goal(input int x, input int y);
        logic mouth;
        mouth = (x >= `SHOOT_POST_INNER) && (x <= `SHOOT_SCREEN_WIDTH - `SHOOT_POST_INNER) &&
                (y >= `SHOOT_CROSSBAR_BOTTOM) && (y <= `SHOOT_POST_BOTTOM);
        return mouth && !in_keeper_box(x, y);
    endfunction

    function automatic logic [11:0] ref_rgb(input int h, input int v,
                                            input shoot_pkg::keeper_tint_t t, input logic [11:0] rgb);
        if (!in_keeper_box(h, v))
            return rgb;
        case (t)
            shoot_pkg::TINT_AIM:  return `SHOOT_RGB_AIM;
            shoot_pkg::TINT_GOAL: return `SHOOT_RGB_GOAL;
            shoot_pkg::TINT_MISS: return `SHOOT_RGB_MISS;
            default:              return rgb;
        endcase
    endfunction

    function automatic int rand_below(input int n);
        int r;
        r = $random(seed);
        return (r & 32'h7fff_ffff) % n;
    endfunction

    task automatic check_val(input string sig, input logic [63:0] exp, input logic [63:0] act);
        assert (act === exp) else begin
            $display("Mismatch %s %s: expected %0h actual %0h", test_name, sig, exp, act);
            errors++;
        end
    endtask

    // expected values, one cycle behind the inputs
    always @(posedge clk) begin
        chk_live   <= !rst;
        exp_valid  <= vga_chk && !rst;
        exp_hcount <= in_hcount;
        exp_vcount <= in_vcount;
        exp_sync   <= {in_hsync, in_vsync, in_hblnk, in_vblnk};
        exp_rgb    <= ref_rgb(in_hcount, in_vcount, exp_tint, in_rgb);
        if (rst) begin
            since <= 99;
        end else if (aim_click && left_clicked) begin
            since    <= 0;   // click edge
            exp_goal <= ref_goal(xpos, ypos);
        end else if (since < 99) begin
            since <= since + 1;
        end
    end

    always @(negedge clk) begin
        if (chk_live) begin
            check_val("is_scored", exp_goal && (since >= 1) && (since <= HOLD), is_scored);
            check_val("round_done", since == HOLD, round_done);
            check_val("end_sh", since == HOLD + 1, end_sh);
        end
        if (exp_valid) begin
            check_val("out_hcount", exp_hcount, out_hcount);
            check_val("out_vcount", exp_vcount, out_vcount);
            check_val("out_sync", exp_sync, {out_hsync, out_vsync, out_hblnk, out_vblnk});
            check_val("out_rgb", exp_rgb, out_rgb);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run still going after %0d cycles", MAX_CYCLES);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    task automatic begin_test(input string name);
        test_name = name;
        test_base = errors;
    endtask

    task automatic end_test();
        @(negedge clk);
        #1;
        tests_run++;
        if (errors != test_base)
            tests_failed++;
        $display("%s: %s, %0d errors", test_name, (errors == test_base) ? "ok" : "failed",
                 errors - test_base);
    endtask

    task automatic drive_pixels(input int count);
        repeat (count) begin
            @(negedge clk);
            if (rand_below(2) == 1) begin   // half of them inside the keeper box
                in_hcount = CNT_W'(`SHOOT_GK_LEFT + rand_below(`SHOOT_GK_RIGHT - `SHOOT_GK_LEFT + 1));
                in_vcount = CNT_W'(`SHOOT_GK_TOP + rand_below(`SHOOT_GK_BOTTOM - `SHOOT_GK_TOP + 1));
            end else begin
                in_hcount = CNT_W'(rand_below(2048));
                in_vcount = CNT_W'(rand_below(2048));
            end
            {in_hsync, in_vsync, in_hblnk, in_vblnk} = 4'(rand_below(16));
            in_rgb  = 12'(rand_below(4096));
            vga_chk = 1'b1;
        end
        @(negedge clk);
        vga_chk = 1'b0;
    endtask

    task automatic enter_aim();
        @(negedge clk);
        game_phase = shoot_pkg::SHOOTER;
        repeat (2) @(negedge clk);
        game_phase = shoot_pkg::MENU;   // in AIM now
        exp_tint   = shoot_pkg::TINT_AIM;
    endtask

    task automatic shoot(input int x, input int y);
        bit seen;
        bit late;
        seen = 1'b0;
        late = !ref_goal(x, y);
        repeat (rand_below(4)) @(negedge clk);
        xpos         = POS_W'(x);
        ypos         = POS_W'(y);
        left_clicked = 1'b1;
        aim_click    = 1'b1;
        @(negedge clk);
        left_clicked = 1'b0;
        aim_click    = 1'b0;
        exp_tint     = shoot_pkg::TINT_NONE;
        xpos         = POS_W'(rand_below(1024));   // captured point must hold
        ypos         = POS_W'(rand_below(1024));
        for (int i = 0; i < 40 && !seen; i++) begin
            @(negedge clk);
            left_clicked = late && (i == 6);   // stray click during the miss display
            seen = end_sh;
        end
        left_clicked = 1'b0;
        assert (seen) else begin
            $display("%s: round did not end, no end_sh pulse within 40 cycles", test_name);
            errors++;
        end
    endtask

    initial begin
        int px;
        int py;
        seed = 32'h2eb0_d68d;
        {errors, cycles, tests_run, tests_failed} = '0;
        rst = 1'b1;
        game_phase = shoot_pkg::MENU;
        {xpos, ypos, left_clicked, vga_chk, aim_click, chk_live, exp_goal} = '0;
        exp_tint = shoot_pkg::TINT_NONE;
        begin_test("reset");
        in_hcount = 11'd777;   // busy inputs while reset holds the outputs
        in_vcount = 11'd333;
        {in_hsync, in_vsync, in_hblnk, in_vblnk} = 4'hf;
        in_rgb = 12'habc;
        repeat (4) @(negedge clk);
        check_val("status", 0, {is_scored, round_done, end_sh});
        check_val("vga_out", 0, {out_hcount, out_vcount, out_hsync, out_vsync,
                                 out_hblnk, out_vblnk, out_rgb});
        rst = 1'b0;
        {in_hcount, in_vcount, in_hsync, in_vsync, in_hblnk, in_vblnk, in_rgb} = '0;
        end_test();

        begin_test("idle_pass");
        drive_pixels(200);
        end_test();

        begin_test("aim_tint");
        enter_aim();
        drive_pixels(300);
        shoot(500, 400);
        end_test();

        for (int r = 0; r < 30; r++) begin
            begin_test($sformatf("round_%0d", r));
            case (r % 4)
                0: begin   // keeper save
                    px = `SHOOT_GK_LEFT + rand_below(`SHOOT_GK_RIGHT - `SHOOT_GK_LEFT + 1);
                    py = `SHOOT_GK_TOP + rand_below(`SHOOT_GK_BOTTOM - `SHOOT_GK_TOP + 1);
                end
                1: begin   // wide of the posts
                    px = (rand_below(2) == 1) ? rand_below(`SHOOT_POST_INNER) :
                         `SHOOT_SCREEN_WIDTH - `SHOOT_POST_INNER + 1 + rand_below(`SHOOT_POST_INNER - 1);
                    py = `SHOOT_CROSSBAR_BOTTOM + rand_below(401);
                end
                2: begin   // left of the keeper, inside the mouth
                    px = `SHOOT_POST_INNER + rand_below(`SHOOT_GK_LEFT - `SHOOT_POST_INNER);
                    py = `SHOOT_CROSSBAR_BOTTOM + rand_below(401);
                end
                default: begin
                    px = rand_below(1024);
                    py = rand_below(800);
                end
            endcase
            enter_aim();
            shoot(px, py);
            end_test();
        end

        begin_test("idle_click");
        xpos = POS_W'(300);
        ypos = POS_W'(300);
        repeat (8) begin
            @(negedge clk);
            left_clicked = ~left_clicked;
        end
        left_clicked = 1'b0;
        repeat (HOLD + 4) @(negedge clk);
        end_test();

        begin_test("engage_drop");
        @(negedge clk);
        game_phase = shoot_pkg::SHOOTER;
        @(negedge clk);
        game_phase = shoot_pkg::MENU;   // back to IDLE at the next edge
        @(negedge clk);
        left_clicked = 1'b1;
        @(negedge clk);
        left_clicked = 1'b0;
        drive_pixels(100);   // no keeper tint expected
        end_test();

        $display("%0d tests, %0d failed, %0d mismatches, %0d cycles",
                 tests_run, tests_failed, errors, cycles);
        if (errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+design
design/shoot_pkg.sv
design/round_fsm.sv
design/shot_judge.sv
design/keeper_overlay.sv
design/shoot_top.sv
bench/shoot_tb.sv

// ==== design/keeper_overlay.sv ====
`timescale 1ns/1ps
// keeper overlay: one register stage on the vga stream, paints the keeper box in the tint colour
`include "shoot_defines.svh"

module keeper_overlay (
    input  logic                    clk,
    input  logic                    rst,
    input  shoot_pkg::keeper_tint_t tint,
    input  logic [`SHOOT_CNT_W-1:0] in_hcount,
    input  logic [`SHOOT_CNT_W-1:0] in_vcount,
    input  logic                    in_hsync,
    input  logic                    in_vsync,
    input  logic                    in_hblnk,
    input  logic                    in_vblnk,
    input  logic [11:0]             in_rgb,
    output logic [`SHOOT_CNT_W-1:0] out_hcount,
    output logic [`SHOOT_CNT_W-1:0] out_vcount,
    output logic                    out_hsync,
    output logic                    out_vsync,
    output logic                    out_hblnk,
    output logic                    out_vblnk,
    output logic [11:0]             out_rgb
);

    logic        in_box;
    logic [11:0] tint_rgb;
    logic [11:0] rgb_nxt;

    assign in_box = (in_hcount >= `SHOOT_GK_LEFT) && (in_hcount <= `SHOOT_GK_RIGHT) &&
                    (in_vcount >= `SHOOT_GK_TOP) && (in_vcount <= `SHOOT_GK_BOTTOM);

    always_comb begin
        case (tint)
            shoot_pkg::TINT_AIM:  tint_rgb = `SHOOT_RGB_AIM;
            shoot_pkg::TINT_GOAL: tint_rgb = `SHOOT_RGB_GOAL;
            shoot_pkg::TINT_MISS: tint_rgb = `SHOOT_RGB_MISS;
            default:              tint_rgb = in_rgb;   // no keeper shown
        endcase
    end

    assign rgb_nxt = (in_box && (tint != shoot_pkg::TINT_NONE)) ? tint_rgb : in_rgb;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_hcount <= '0;
            out_vcount <= '0;
            out_hsync  <= 1'b0;
            out_vsync  <= 1'b0;
            out_hblnk  <= 1'b0;
            out_vblnk  <= 1'b0;
            out_rgb    <= '0;
        end else begin
            out_hcount <= in_hcount;
            out_vcount <= in_vcount;
            out_hsync  <= in_hsync;
            out_vsync  <= in_vsync;
            out_hblnk  <= in_hblnk;
            out_vblnk  <= in_vblnk;
            out_rgb    <= rgb_nxt;
        end
    end

    a_pass_untinted: assert property (
        @(posedge clk) disable iff (rst)
        (!$past(rst) && ($past(tint) == shoot_pkg::TINT_NONE)) |-> (out_rgb == $past(in_rgb))
    );

endmodule

// ==== design/round_fsm.sv ====
`timescale 1ns/1ps
// round fsm: sequences one solo shooter round, holds the verdict and flags the round end
module round_fsm #(
    parameter int hold_cycles = 20
) (
    input  logic                    clk,
    input  logic                    rst,
    input  shoot_pkg::game_phase_t  game_phase,
    input  logic                    left_clicked,
    input  logic                    goal,
    output logic                    capture,
    output shoot_pkg::keeper_tint_t tint,
    output logic                    is_scored,
    output logic                    round_done,
    output logic                    end_sh
);

    localparam int CNT_W = (hold_cycles > 1) ? $clog2(hold_cycles) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(hold_cycles - 1);

    shoot_pkg::round_state_t state;
    shoot_pkg::round_state_t state_nxt;
    shoot_pkg::keeper_tint_t tint_nxt;
    logic [CNT_W-1:0]        cnt;
    logic [CNT_W-1:0]        cnt_nxt;
    logic                    hold_end;
    logic                    hold_nxt;

    assign capture  = (state == shoot_pkg::AIM) && left_clicked;  // single cycle, AIM only
    assign hold_end = (cnt == CNT_LAST);
    assign hold_nxt = (state_nxt == shoot_pkg::GOAL) || (state_nxt == shoot_pkg::MISS);

    always_comb begin
        state_nxt = state;
        cnt_nxt   = '0;
        case (state)
            shoot_pkg::IDLE: begin
                if (game_phase == shoot_pkg::SHOOTER)
                    state_nxt = shoot_pkg::ENGAGE;
            end
            shoot_pkg::ENGAGE: begin
                if (game_phase == shoot_pkg::SHOOTER)
                    state_nxt = shoot_pkg::AIM;
                else
                    state_nxt = shoot_pkg::IDLE;  // phase dropped, no round
            end
            shoot_pkg::AIM: begin
                if (capture)
                    state_nxt = shoot_pkg::RESULT;
            end
            shoot_pkg::RESULT: begin
                state_nxt = goal ? shoot_pkg::GOAL : shoot_pkg::MISS;
            end
            shoot_pkg::GOAL, shoot_pkg::MISS: begin
                if (hold_end)
                    state_nxt = shoot_pkg::TERMINATE;
                else
                    cnt_nxt = cnt + CNT_W'(1);
            end
            shoot_pkg::TERMINATE: begin
                state_nxt = shoot_pkg::IDLE;
            end
            default: begin
                state_nxt = shoot_pkg::IDLE;
            end
        endcase
    end

    // keeper colour follows the state one for one
    always_comb begin
        case (state_nxt)
            shoot_pkg::AIM,
            shoot_pkg::RESULT: tint_nxt = shoot_pkg::TINT_AIM;
            shoot_pkg::GOAL:   tint_nxt = shoot_pkg::TINT_GOAL;
            shoot_pkg::MISS:   tint_nxt = shoot_pkg::TINT_MISS;
            default:           tint_nxt = shoot_pkg::TINT_NONE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= shoot_pkg::IDLE;
            cnt        <= '0;
            tint       <= shoot_pkg::TINT_NONE;
            is_scored  <= 1'b0;
            round_done <= 1'b0;
            end_sh     <= 1'b0;
        end else begin
            state      <= state_nxt;
            cnt        <= cnt_nxt;
            tint       <= tint_nxt;
            is_scored  <= (state_nxt == shoot_pkg::GOAL);
            round_done <= hold_nxt && (cnt_nxt == CNT_LAST);  // last hold cycle
            end_sh     <= (state_nxt == shoot_pkg::TERMINATE);
        end
    end

    a_done_in_hold: assert property (
        @(posedge clk) disable iff (rst)
        round_done |-> (state == shoot_pkg::GOAL) || (state == shoot_pkg::MISS)
    );

    // the end pulse comes only after the goal display has finished
    a_scored_end_excl: assert property (
        @(posedge clk) disable iff (rst)
        !(is_scored && end_sh)
    );

endmodule

// ==== design/shoot_defines.svh ====
// shoot defines: screen, goal mouth and keeper geometry, tint colours, verdict hold time
`ifndef SHOOT_DEFINES_SVH
`define SHOOT_DEFINES_SVH

// screen and pointer
`define SHOOT_SCREEN_WIDTH    1024
`define SHOOT_POS_W           12     // mouse coordinate width
`define SHOOT_CNT_W           11     // vga pixel counter width

// goal mouth, right post mirrors the left one
`define SHOOT_POST_INNER      112
`define SHOOT_CROSSBAR_BOTTOM 200
`define SHOOT_POST_BOTTOM     600

// keeper box, inclusive bounds
`define SHOOT_GK_LEFT         400
`define SHOOT_GK_RIGHT        600
`define SHOOT_GK_TOP          250
`define SHOOT_GK_BOTTOM       550

// keeper tint colours, 4 bits per channel
`define SHOOT_RGB_AIM         12'h0_0_F   // blue
`define SHOOT_RGB_GOAL        12'h0_F_0   // green
`define SHOOT_RGB_MISS        12'h F_0_0  // red

// verdict display, roughly a quarter second at 50 MHz
`define SHOOT_HOLD_CYCLES     13003902

`endif

// ==== design/shoot_pkg.sv ====
// shoot package: game phase, shooter round state and keeper tint encodings
package shoot_pkg;

    // phase of the whole game, driven from the main game FSM
    typedef enum logic [1:0] {
        MENU,
        SHOOTER,
        KEEPER,
        OVER
    } game_phase_t;

    typedef enum logic [2:0] {
        IDLE,
        ENGAGE,      // phase seen once, wait for a second sample
        AIM,
        RESULT,
        GOAL,
        MISS,
        TERMINATE
    } round_state_t;

    // colour choice for the keeper box
    typedef enum logic [1:0] {
        TINT_NONE,
        TINT_AIM,
        TINT_GOAL,
        TINT_MISS
    } keeper_tint_t;

endpackage

// ==== design/shoot_top.sv ====
`timescale 1ns/1ps
// shoot top: solo penalty shooter, round control, shot judging and keeper overlay
`include "shoot_defines.svh"

module shoot_top #(
    parameter int hold_cycles = `SHOOT_HOLD_CYCLES
) (
    input  logic                    clk,
    input  logic                    rst,
    input  shoot_pkg::game_phase_t  game_phase,
    input  logic [`SHOOT_POS_W-1:0] xpos,
    input  logic [`SHOOT_POS_W-1:0] ypos,
    input  logic                    left_clicked,
    input  logic [`SHOOT_CNT_W-1:0] in_hcount,
    input  logic [`SHOOT_CNT_W-1:0] in_vcount,
    input  logic                    in_hsync,
    input  logic                    in_vsync,
    input  logic                    in_hblnk,
    input  logic                    in_vblnk,
    input  logic [11:0]             in_rgb,
    output logic                    is_scored,
    output logic                    round_done,
    output logic                    end_sh,
    output logic [`SHOOT_CNT_W-1:0] out_hcount,
    output logic [`SHOOT_CNT_W-1:0] out_vcount,
    output logic                    out_hsync,
    output logic                    out_vsync,
    output logic                    out_hblnk,
    output logic                    out_vblnk,
    output logic [11:0]             out_rgb
);

    logic                    capture;
    logic                    goal;
    shoot_pkg::keeper_tint_t tint;

    round_fsm #(
        .hold_cycles (hold_cycles)
    ) u_round_fsm (
        .clk          (clk),
        .rst          (rst),
        .game_phase   (game_phase),
        .left_clicked (left_clicked),
        .goal         (goal),
        .capture      (capture),
        .tint         (tint),
        .is_scored    (is_scored),
        .round_done   (round_done),
        .end_sh       (end_sh)
    );

    shot_judge u_shot_judge (
        .clk     (clk),
        .rst     (rst),
        .capture (capture),
        .xpos    (xpos),
        .ypos    (ypos),
        .goal    (goal)
    );

    keeper_overlay u_keeper_overlay (
        .clk        (clk),
        .rst        (rst),
        .tint       (tint),
        .in_hcount  (in_hcount),
        .in_vcount  (in_vcount),
        .in_hsync   (in_hsync),
        .in_vsync   (in_vsync),
        .in_hblnk   (in_hblnk),
        .in_vblnk   (in_vblnk),
        .in_rgb     (in_rgb),
        .out_hcount (out_hcount),
        .out_vcount (out_vcount),
        .out_hsync  (out_hsync),
        .out_vsync  (out_vsync),
        .out_hblnk  (out_hblnk),
        .out_vblnk  (out_vblnk),
        .out_rgb    (out_rgb)
    );

endmodule

// ==== design/shot_judge.sv ====
`timescale 1ns/1ps
// shot judge: latches the pointer on a click and decides goal or miss
`include "shoot_defines.svh"

module shot_judge (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    capture,
    input  logic [`SHOOT_POS_W-1:0] xpos,
    input  logic [`SHOOT_POS_W-1:0] ypos,
    output logic                    goal
);

    logic in_mouth;
    logic in_keeper;
    logic verdict;

    // goal mouth between the posts, below the crossbar
    assign in_mouth = (xpos >= `SHOOT_POST_INNER) &&
                      (xpos <= `SHOOT_SCREEN_WIDTH - `SHOOT_POST_INNER) &&
                      (ypos >= `SHOOT_CROSSBAR_BOTTOM) &&
                      (ypos <= `SHOOT_POST_BOTTOM);

    assign in_keeper = (xpos >= `SHOOT_GK_LEFT) &&
                       (xpos <= `SHOOT_GK_RIGHT) &&
                       (ypos >= `SHOOT_GK_TOP) &&
                       (ypos <= `SHOOT_GK_BOTTOM);

    assign verdict = in_mouth && !in_keeper;  // keeper saves anything in his box

    always_ff @(posedge clk) begin
        if (rst) begin
            goal <= 1'b0;
        end else if (capture) begin
            goal <= verdict;
        end
    end

    a_goal_known: assert property (
        @(posedge clk) disable iff (rst)
        !$isunknown(goal)
    );

endmodule
